// File: Makefile
SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

obj_dir/Vtb_cpu: project.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_cpu -f project.f -o Vtb_cpu

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: project.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/memory.sv
verilog/cpu.sv
tb/tb_cpu.sv

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;

    // reset, five programs of up to ~20 words, a 40-cycle bound and drain each
    localparam int CYCLE_LIMIT = 400;
    localparam int HALT_BOUND = 40;

    localparam int IO_HI = `IO_LED_ADDR >> 12;
    localparam int LED_OFF = `IO_LED_ADDR & 32'hfff;
    localparam int SEG_OFF = `IO_SEG_ADDR & 32'hfff;
    localparam int SW_OFF = `IO_SW_ADDR & 32'hfff;

    logic           cpuclk;
    logic           rst;
    logic           uart_done;
    cpu_pkg::word_t uart_data;
    cpu_pkg::word_t uart_addr;
    cpu_pkg::led_t  switches;
    cpu_pkg::led_t  led_out;
    cpu_pkg::word_t seg_out;
    cpu_pkg::word_t pc_t;
    cpu_pkg::word_t inst_t;

    cpu_pkg::word_t prog [$];
    int             errors;
    int             checks;
    int             cycle_count;

    cpu dut (
        .cpuclk,
        .rst,
        .uart_data,
        .uart_addr,
        .uart_done,
        .switches,
        .led_out,
        .seg_out,
        .pc_t,
        .inst_t
    );

    initial begin
        cpuclk = 1'b0;
        forever begin
            #50;
            cpuclk = ~cpuclk;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge cpuclk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles", cycle_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // rv32i instruction formats
    function automatic cpu_pkg::word_t r_format(input int f7, input int f3, input int rd,
                                                input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], cpu_pkg::OP_OP};
    endfunction

    function automatic cpu_pkg::word_t i_format(input logic [6:0] op, input int f3,
                                                input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic cpu_pkg::word_t s_format(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], cpu_pkg::OP_STORE};
    endfunction

    function automatic cpu_pkg::word_t b_format(input int f3, input int rs1, input int rs2,
                                                input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                cpu_pkg::OP_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t u_format(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], cpu_pkg::OP_LUI};
    endfunction

    function automatic cpu_pkg::word_t j_format(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], cpu_pkg::OP_JAL};
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_led(input string name, input cpu_pkg::led_t got,
                             input cpu_pkg::led_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // load prog through the uart port, start the core and wait for the halt loop
    task automatic run_program(input string name);
        int             i;
        int             waited;
        cpu_pkg::word_t halt_pc;
        halt_pc = (prog.size() - 1) * 4;
        @(posedge cpuclk);
        #5;
        uart_done = 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            uart_addr = i * 4;
            uart_data = prog[i];
            @(posedge cpuclk);
            #5;
        end
        uart_done = 1'b1;
        check_word("pc_t", pc_t, 32'h0);
        waited = 0;
        while (pc_t !== halt_pc && waited < HALT_BOUND) begin
            @(posedge cpuclk);
            #5;
            waited++;
        end
        if (pc_t !== halt_pc) begin
            errors++;
            $display("program %s never reached its halt loop within %0d cycles",
                     name, HALT_BOUND);
        end else begin
            // the word just ahead of the halt sits in IF/ID
            check_word("inst_t", inst_t, prog[prog.size() - 2]);
        end
        // store just ahead of the halt reaches memory three edges later
        repeat (3) begin
            @(posedge cpuclk);
        end
        #5;
    endtask

    task automatic reset_and_load();
        check_led("led_out", led_out, 16'h0);
        check_word("seg_out", seg_out, 32'h0);
        prog.delete();
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 1, 0, 5));
        prog.push_back(j_format(0, 0));
        run_program("reset_and_load");
        check_led("led_out", led_out, 16'h0);
        check_word("seg_out", seg_out, 32'h0);
    endtask

    task automatic alu_forwarding();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t r;
        cpu_pkg::word_t s;
        cpu_pkg::word_t t;
        cpu_pkg::word_t u;
        cpu_pkg::word_t v;
        cpu_pkg::word_t w;
        a = $urandom & 32'h7ff;
        b = $urandom & 32'h7ff;
        r = a + b;
        s = a - r;
        t = s & r;
        u = t | a;
        v = u ^ s;
        w = ($signed(s) < $signed(v)) ? 32'd1 : 32'd0;
        prog.delete();
        prog.push_back(u_format(10, IO_HI));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 1, 0, a));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 2, 0, b));
        prog.push_back(r_format(7'h00, 3'b000, 3, 1, 2));
        prog.push_back(r_format(7'h20, 3'b000, 4, 1, 3));
        prog.push_back(r_format(7'h00, 3'b111, 5, 4, 3));
        prog.push_back(r_format(7'h00, 3'b110, 6, 5, 1));
        prog.push_back(r_format(7'h00, 3'b100, 7, 6, 4));
        prog.push_back(r_format(7'h00, 3'b010, 8, 4, 7));
        prog.push_back(r_format(7'h00, 3'b000, 9, 8, 7));
        prog.push_back(s_format(10, 9, SEG_OFF));
        prog.push_back(j_format(0, 0));
        run_program("alu_forwarding");
        check_word("seg_out", seg_out, v + w);
    endtask

    task automatic load_use_hazard();
        cpu_pkg::word_t stored;
        int             imm;
        stored = 32'h1234_5678;
        imm = -3;
        prog.delete();
        prog.push_back(u_format(10, IO_HI));
        prog.push_back(u_format(1, stored[31:12]));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 1, 1, stored[11:0]));
        prog.push_back(s_format(0, 1, 256));
        prog.push_back(i_format(cpu_pkg::OP_LOAD, 3'b010, 2, 0, 256));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 3, 2, imm));
        prog.push_back(s_format(10, 3, SEG_OFF));
        prog.push_back(j_format(0, 0));
        run_program("load_use_hazard");
        check_word("seg_out", seg_out, stored + cpu_pkg::word_t'(imm));
    endtask

    task automatic branch_flush();
        int             p;
        int             q;
        cpu_pkg::word_t count;
        p = 7;
        q = 7;
        count = 1;
        if (p != q) begin
            count += 300;
        end
        count += 2;
        if (p == q) begin
            count += 4;
        end
        count += 16;
        prog.delete();
        prog.push_back(u_format(10, IO_HI));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 0, 1));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 6, 0, p));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 7, 0, q));
        prog.push_back(b_format(3'b000, 6, 7, 12));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 100));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 200));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 2));
        prog.push_back(b_format(3'b001, 6, 7, 8));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 4));
        prog.push_back(j_format(0, 8));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 64));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 0, 5, 5, 16));
        prog.push_back(s_format(10, 5, SEG_OFF));
        prog.push_back(j_format(0, 0));
        run_program("branch_flush");
        check_word("seg_out", seg_out, count);
    endtask

    task automatic board_io();
        cpu_pkg::word_t hi;
        cpu_pkg::word_t lo;
        hi = 32'hcafe0;
        lo = 32'h5a5;
        @(posedge cpuclk);
        #5;
        switches = $urandom & 32'hffff;
        prog.delete();
        prog.push_back(u_format(10, IO_HI));
        prog.push_back(i_format(cpu_pkg::OP_LOAD, 3'b010, 1, 10, SW_OFF));
        prog.push_back(s_format(10, 1, LED_OFF));
        prog.push_back(u_format(2, hi));
        prog.push_back(i_format(cpu_pkg::OP_OPIMM, 3'b110, 2, 2, lo));
        prog.push_back(s_format(10, 2, SEG_OFF));
        prog.push_back(j_format(0, 0));
        run_program("board_io");
        check_led("led_out", led_out, switches);
        check_word("seg_out", seg_out, (hi << 12) | lo);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst = 1'b1;
        uart_done = 1'b0;
        uart_data = '0;
        uart_addr = '0;
        switches = '0;
        void'($urandom(32'hb320));
        repeat (16) begin
            @(posedge cpuclk);
        end
        #5;
        rst = 1'b0;
        reset_and_load();
        alu_forwarding();
        load_use_hazard();
        branch_flush();
        board_io();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic           cpuclk,
    input  logic           rst,
    input  cpu_pkg::word_t uart_data,
    input  cpu_pkg::word_t uart_addr,
    input  logic           uart_done,
    input  cpu_pkg::led_t  switches,
    output cpu_pkg::led_t  led_out,
    output cpu_pkg::word_t seg_out,
    output cpu_pkg::word_t pc_t,
    output cpu_pkg::word_t inst_t
);

    logic              core_rst;
    logic              stall;
    logic              redirect;
    cpu_pkg::word_t    redirect_pc;
    cpu_pkg::word_t    imem_addr;
    cpu_pkg::word_t    imem_data;
    cpu_pkg::word_t    dmem_addr;
    cpu_pkg::word_t    dmem_wdata;
    cpu_pkg::word_t    dmem_rdata;
    logic              dmem_we;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;
    logic              wb_we;

    if_id_if  if_id ();
    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    // core sits in reset while the program is loading
    assign core_rst = rst || !uart_done;

    assign pc_t   = imem_addr;
    assign inst_t = if_id.inst;

    fetch_stage u_fetch (
        .cpuclk,
        .rst(core_rst),
        .stall,
        .redirect,
        .redirect_pc,
        .imem_data,
        .imem_addr,
        .if_id(if_id.src)
    );

    decode_stage u_decode (
        .cpuclk,
        .rst(core_rst),
        .redirect,
        .wb_rd,
        .wb_data,
        .wb_we,
        .stall,
        .if_id(if_id.dst),
        .id_ex(id_ex.src)
    );

    execute_stage u_execute (
        .cpuclk,
        .rst(core_rst),
        .wb_rd,
        .wb_data,
        .wb_we,
        .redirect,
        .redirect_pc,
        .id_ex(id_ex.dst),
        .ex_mem(ex_mem.src)
    );

    mem_stage u_mem (
        .cpuclk,
        .rst(core_rst),
        .dmem_rdata,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .wb_rd,
        .wb_data,
        .wb_we,
        .ex_mem(ex_mem.dst)
    );

    // board outputs survive program loading
    memory u_memory (
        .cpuclk,
        .rst,
        .uart_data,
        .uart_addr,
        .uart_done,
        .imem_addr,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .switches,
        .imem_data,
        .dmem_rdata,
        .led_out,
        .seg_out
    );

endmodule

// File: verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// unified RAM depth in 32-bit words
`define MEM_WORDS 256

// upper 20 address bits of the I/O page
`define IO_PAGE 20'hFFFFF

// memory-mapped board I/O
`define IO_LED_ADDR 32'hFFFF_F000
`define IO_SEG_ADDR 32'hFFFF_F004
`define IO_SW_ADDR  32'hFFFF_F008

`endif

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [15:0] led_t;

    // alu operations
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLT   = 4'd5;
    localparam alu_op_t ALU_PASSB = 4'd6;

    // rv32i major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              cpuclk,
    input  logic              rst,
    input  logic              redirect,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    input  logic              wb_we,
    output logic              stall,
    if_id_if.dst              if_id,
    id_ex_if.src              id_ex
);

    cpu_pkg::word_t    regs [32];
    cpu_pkg::word_t    inst;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    rs1_val;
    cpu_pkg::word_t    rs2_val;
    cpu_pkg::reg_idx_t rs1;
    cpu_pkg::reg_idx_t rs2;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::alu_op_t  f3_op;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alu_src_imm;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              is_branch;
    logic              is_jal;
    logic              is_lui;
    logic              take;

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // shared by op and op-imm, bit 30 only means sub on register ops
    always_comb begin
        case (funct3)
            3'b000: f3_op = (opcode == cpu_pkg::OP_OP && inst[30]) ? cpu_pkg::ALU_SUB
                                                                   : cpu_pkg::ALU_ADD;
            3'b010: f3_op = cpu_pkg::ALU_SLT;
            3'b100: f3_op = cpu_pkg::ALU_XOR;
            3'b110: f3_op = cpu_pkg::ALU_OR;
            3'b111: f3_op = cpu_pkg::ALU_AND;
            default: f3_op = cpu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        imm = '0;
        alu_op = cpu_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        is_lui = 1'b0;
        case (opcode)
            cpu_pkg::OP_LUI: begin
                imm = {inst[31:12], 12'b0};
                alu_op = cpu_pkg::ALU_PASSB;
                alu_src_imm = 1'b1;
                reg_write = 1'b1;
                is_lui = 1'b1;
            end
            cpu_pkg::OP_OPIMM: begin
                imm = {{20{inst[31]}}, inst[31:20]};
                alu_op = f3_op;
                alu_src_imm = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_OP: begin
                alu_op = f3_op;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                imm = {{20{inst[31]}}, inst[31:20]};
                alu_src_imm = 1'b1;
                mem_read = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                alu_src_imm = 1'b1;
                mem_write = 1'b1;
            end
            cpu_pkg::OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                alu_op = cpu_pkg::ALU_SUB;
                is_branch = 1'b1;
            end
            cpu_pkg::OP_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                reg_write = 1'b1;
                is_jal = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge cpuclk) begin
        if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 reads as zero, a same-cycle writeback is read through
    always_comb begin
        rs1_val = regs[rs1];
        if (rs1 == '0) begin
            rs1_val = '0;
        end else if (wb_we && wb_rd == rs1) begin
            rs1_val = wb_data;
        end
        rs2_val = regs[rs2];
        if (rs2 == '0) begin
            rs2_val = '0;
        end else if (wb_we && wb_rd == rs2) begin
            rs2_val = wb_data;
        end
    end

    // load in execute feeding the instruction in decode
    assign stall = if_id.valid && id_ex.valid && id_ex.mem_read && id_ex.rd != '0
                   && (id_ex.rd == rs1 || id_ex.rd == rs2);

    assign take = if_id.valid && !stall && !redirect;

    always_ff @(posedge cpuclk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
            id_ex.mem_read <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal <= 1'b0;
        end else begin
            id_ex.valid <= take;
            id_ex.mem_read <= take && mem_read;
            id_ex.mem_write <= take && mem_write;
            id_ex.reg_write <= take && reg_write && rd != '0;
            id_ex.is_branch <= take && is_branch;
            id_ex.is_jal <= take && is_jal;
        end
    end

    always_ff @(posedge cpuclk) begin
        id_ex.pc <= if_id.pc;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm <= imm;
        id_ex.rs1 <= rs1;
        id_ex.rs2 <= rs2;
        id_ex.rd <= rd;
        id_ex.alu_op <= alu_op;
        id_ex.alu_src_imm <= alu_src_imm;
        id_ex.branch_ne <= funct3[0];
        id_ex.is_lui <= is_lui;
    end

    wb_no_x0: assert property (@(posedge cpuclk) disable iff (rst) wb_we |-> wb_rd != '0)
        else $error("writeback targets x0");

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              cpuclk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    input  logic              wb_we,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc,
    id_ex_if.dst              id_ex,
    ex_mem_if.src             ex_mem
);

    cpu_pkg::word_t fwd_a;
    cpu_pkg::word_t fwd_b;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t result;
    logic           rs1_live;
    logic           branch_hit;

    // u and j formats carry immediate bits in the rs1 field
    assign rs1_live = !(id_ex.is_lui || id_ex.is_jal);

    // memory stage has priority over writeback
    always_comb begin
        fwd_a = id_ex.rs1_val;
        if (rs1_live && ex_mem.reg_write && ex_mem.rd == id_ex.rs1) begin
            fwd_a = ex_mem.alu_res;
        end else if (rs1_live && wb_we && wb_rd == id_ex.rs1) begin
            fwd_a = wb_data;
        end
        fwd_b = id_ex.rs2_val;
        if (ex_mem.reg_write && ex_mem.rd == id_ex.rs2) begin
            fwd_b = ex_mem.alu_res;
        end else if (wb_we && wb_rd == id_ex.rs2) begin
            fwd_b = wb_data;
        end
    end

    assign op_b = id_ex.alu_src_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_ADD:   alu_out = fwd_a + op_b;
            cpu_pkg::ALU_SUB:   alu_out = fwd_a - op_b;
            cpu_pkg::ALU_AND:   alu_out = fwd_a & op_b;
            cpu_pkg::ALU_OR:    alu_out = fwd_a | op_b;
            cpu_pkg::ALU_XOR:   alu_out = fwd_a ^ op_b;
            cpu_pkg::ALU_SLT:   alu_out = {31'b0, $signed(fwd_a) < $signed(op_b)};
            cpu_pkg::ALU_PASSB: alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    // branches subtract, so equal operands give zero
    assign branch_hit = id_ex.branch_ne ? (alu_out != '0) : (alu_out == '0);

    // decode already clears the branch and jal bits of a bubble
    assign redirect = (id_ex.is_branch && branch_hit) || id_ex.is_jal;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // jal links the return address
    assign result = id_ex.is_jal ? id_ex.pc + 32'd4 : alu_out;

    always_ff @(posedge cpuclk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
            ex_mem.mem_read <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.mem_read <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
        end
    end

    always_ff @(posedge cpuclk) begin
        ex_mem.alu_res <= result;
        ex_mem.store_data <= fwd_b;
        ex_mem.rd <= id_ex.rd;
    end

    redirect_valid: assert property (@(posedge cpuclk) disable iff (rst)
                                     redirect |-> id_ex.valid)
        else $error("redirect from a bubble in execute");

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           cpuclk,
    input  logic           rst,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t imem_addr,
    if_id_if.src           if_id
);

    cpu_pkg::word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge cpuclk) begin
        if (rst) begin
            pc <= '0;
            if_id.valid <= 1'b0;
        end else if (redirect) begin
            // taken branch wins over a load-use stall
            pc <= redirect_pc;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            pc <= pc + 32'd4;
            if_id.valid <= 1'b1;
        end
    end

    always_ff @(posedge cpuclk) begin
        if (!stall || redirect) begin
            if_id.pc <= pc;
            if_id.inst <= imem_data;
        end
    end

    // branch targets come from execute, so alignment depends on the imm path
    pc_aligned: assert property (@(posedge cpuclk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              cpuclk,
    input  logic              rst,
    input  cpu_pkg::word_t    dmem_rdata,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_we,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data,
    output logic              wb_we,
    ex_mem_if.dst             ex_mem
);

    cpu_pkg::word_t alu_q;
    cpu_pkg::word_t load_q;
    logic           load_sel;

    assign dmem_addr  = ex_mem.alu_res;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge cpuclk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_mem.valid && ex_mem.reg_write;
        end
    end

    always_ff @(posedge cpuclk) begin
        wb_rd <= ex_mem.rd;
        alu_q <= ex_mem.alu_res;
        load_q <= dmem_rdata;
        load_sel <= ex_mem.mem_read;
    end

    assign wb_data = load_sel ? load_q : alu_q;

endmodule

// File: verilog/memory.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory (
    input  logic           cpuclk,
    input  logic           rst,
    input  cpu_pkg::word_t uart_data,
    input  cpu_pkg::word_t uart_addr,
    input  logic           uart_done,
    input  cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t dmem_addr,
    input  cpu_pkg::word_t dmem_wdata,
    input  logic           dmem_we,
    input  cpu_pkg::led_t  switches,
    output cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t dmem_rdata,
    output cpu_pkg::led_t  led_out,
    output cpu_pkg::word_t seg_out
);

    localparam int AW = $clog2(`MEM_WORDS);

    cpu_pkg::word_t ram [`MEM_WORDS];
    cpu_pkg::word_t wr_addr;
    cpu_pkg::word_t wr_data;
    logic           wr_en;
    logic           wr_io;

    // loader owns the write port until uart_done
    assign wr_addr = uart_done ? dmem_addr : uart_addr;
    assign wr_data = uart_done ? dmem_wdata : uart_data;
    assign wr_en   = !uart_done || dmem_we;
    assign wr_io   = wr_addr[31:12] == `IO_PAGE;

    always_ff @(posedge cpuclk) begin
        if (wr_en && !wr_io) begin
            ram[wr_addr[AW+1:2]] <= wr_data;
        end
    end

    assign imem_data = ram[imem_addr[AW+1:2]];

    always_comb begin
        case (dmem_addr)
            `IO_LED_ADDR: dmem_rdata = {16'b0, led_out};
            `IO_SEG_ADDR: dmem_rdata = seg_out;
            `IO_SW_ADDR:  dmem_rdata = {16'b0, switches};
            default:      dmem_rdata = ram[dmem_addr[AW+1:2]];
        endcase
    end

    always_ff @(posedge cpuclk) begin
        if (rst) begin
            led_out <= '0;
            seg_out <= '0;
        end else if (wr_en && wr_addr == `IO_LED_ADDR) begin
            led_out <= wr_data[15:0];
        end else if (wr_en && wr_addr == `IO_SEG_ADDR) begin
            seg_out <= wr_data;
        end
    end

endmodule

// File: verilog/pipe_if.sv
`timescale 1ns/1ps

interface if_id_if;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t inst;
    logic           valid;

    modport src (output pc, inst, valid);
    modport dst (input pc, inst, valid);
endinterface

interface id_ex_if;
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    rs1_val;
    cpu_pkg::word_t    rs2_val;
    cpu_pkg::word_t    imm;
    cpu_pkg::reg_idx_t rs1;
    cpu_pkg::reg_idx_t rs2;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::alu_op_t  alu_op;
    logic              alu_src_imm;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              is_branch;
    logic              branch_ne;
    logic              is_jal;
    logic              is_lui;
    logic              valid;

    modport src (output pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, alu_src_imm,
                 mem_read, mem_write, reg_write, is_branch, branch_ne, is_jal, is_lui, valid);
    modport dst (input pc, rs1_val, rs2_val, imm, rs1, rs2, rd, alu_op, alu_src_imm,
                 mem_read, mem_write, reg_write, is_branch, branch_ne, is_jal, is_lui, valid);
endinterface

interface ex_mem_if;
    cpu_pkg::word_t    alu_res;
    cpu_pkg::word_t    store_data;
    cpu_pkg::reg_idx_t rd;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              valid;

    modport src (output alu_res, store_data, rd, mem_read, mem_write, reg_write, valid);
    modport dst (input alu_res, store_data, rd, mem_read, mem_write, reg_write, valid);
endinterface
